/* src.f */
+incdir+source
source/mmap_pkg.sv
source/sync_fifo.sv
source/burst_detector.sv
source/w_channel.sv
source/write_resp_tracker.sv
source/async_mmap_write.sv
dv/tb_axi_slave.sv
dv/tb_async_mmap_write.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_async_mmap_write -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_async_mmap_write)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the verdict line decides the result
if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

/* dv/tb_async_mmap_write.sv */
`default_nettype none

`include "mmap_defines.svh"

module tb_async_mmap_write
  import mmap_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam wait_t      max_wait     = wait_t'(6);
  localparam burst_len_t max_len      = burst_len_t'(3);
  localparam addr_t      step         = addr_t'(`MMAP_BYTES_PER_BEAT);
  localparam int         num_groups   = 6;
  localparam int         total_words  = 44;
  localparam int         limit_cycles = total_words * 40 + num_groups * 60;

  logic       clk;
  logic       rst;
  addr_t      write_addr_din;
  logic       write_addr_write;
  logic       write_addr_full_n;
  data_t      write_data_din;
  logic       write_data_write;
  logic       write_data_full_n;
  burst_len_t write_resp_dout;
  logic       write_resp_read;
  logic       write_resp_empty_n;
  logic       awvalid;
  logic       awready;
  addr_t      awaddr;
  burst_len_t awlen;
  logic       wvalid;
  logic       wready;
  data_t      wdata;
  logic       wlast;
  logic       bvalid;
  logic       bready;

  // current group, expected results and observed results
  addr_t      grp_addr[$];
  data_t      grp_data[$];
  addr_t      exp_aw_addr[$];
  burst_len_t exp_aw_len[$];
  data_t      exp_w_data[$];
  logic       exp_w_last[$];
  burst_len_t exp_resp[$];
  addr_t      obs_aw_addr[$];
  burst_len_t obs_aw_len[$];
  data_t      obs_w_data[$];
  logic       obs_w_last[$];
  burst_len_t obs_resp[$];

  int    seed = 32'h52c4;
  int    aw_seen = 0;
  int    w_seen = 0;
  int    aw_total = 0;
  int    w_total = 0;
  int    aw_errors = 0;
  int    w_errors = 0;
  int    b_errors = 0;
  int    other_errors = 0;
  string test_name = "reset";

  async_mmap_write u_dut (
    .clk               (clk),
    .rst               (rst),
    .max_wait_time     (max_wait),
    .max_burst_len     (max_len),
    .write_addr_din    (write_addr_din),
    .write_addr_write  (write_addr_write),
    .write_addr_full_n (write_addr_full_n),
    .write_data_din    (write_data_din),
    .write_data_write  (write_data_write),
    .write_data_full_n (write_data_full_n),
    .write_resp_dout   (write_resp_dout),
    .write_resp_read   (write_resp_read),
    .write_resp_empty_n(write_resp_empty_n),
    .m_axi_awvalid     (awvalid),
    .m_axi_awready     (awready),
    .m_axi_awaddr      (awaddr),
    .m_axi_awlen       (awlen),
    .m_axi_wvalid      (wvalid),
    .m_axi_wready      (wready),
    .m_axi_wdata       (wdata),
    .m_axi_wlast       (wlast),
    .m_axi_bvalid      (bvalid),
    .m_axi_bready      (bready)
  );

  tb_axi_slave u_slave (
    .clk    (clk),
    .rst    (rst),
    .awready(awready),
    .wvalid (wvalid),
    .wready (wready),
    .wlast  (wlast),
    .bvalid (bvalid),
    .bready (bready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // expected bursts split on a gap or after max_len + 1 beats
  function automatic void split_bursts(input addr_t addrs[$], input data_t words[$]);
    addr_t      first;
    burst_len_t len;
    logic       starts[$];
    int         i;
    first = '0;
    len   = '0;
    for (i = 0; i < addrs.size(); i++) begin
      if (i == 0) begin
        starts.push_back(1'b1);
      end else if (addrs[i] != addrs[i - 1] + step || len == max_len) begin
        starts.push_back(1'b1);
      end else begin
        starts.push_back(1'b0);
      end
      if (starts[i]) begin
        if (i > 0) begin
          exp_aw_addr.push_back(first);
          exp_aw_len.push_back(len);
          exp_resp.push_back(len);
          aw_total++;
        end
        first = addrs[i];
        len   = '0;
      end else begin
        len = len + 1'b1;
      end
    end
    if (addrs.size() > 0) begin
      exp_aw_addr.push_back(first);
      exp_aw_len.push_back(len);
      exp_resp.push_back(len);
      aw_total++;
    end
    for (i = 0; i < addrs.size(); i++) begin
      exp_w_data.push_back(words[i]);
      exp_w_last.push_back(i == addrs.size() - 1 || starts[i + 1]);
      w_total++;
    end
  endfunction

  task automatic check_burst(input addr_t exp_addr, input burst_len_t exp_len,
                             input addr_t act_addr, input burst_len_t act_len);
    if (exp_addr !== act_addr || exp_len !== act_len) begin
      aw_errors++;
      $display("error %s: AW expected addr %h len %0d, actual addr %h len %0d",
               test_name, exp_addr, exp_len, act_addr, act_len);
    end
  endtask

  task automatic check_beat(input data_t exp_data, input logic exp_last,
                            input data_t act_data, input logic act_last);
    if (exp_data !== act_data || exp_last !== act_last) begin
      w_errors++;
      $display("error %s: W expected data %h last %b, actual data %h last %b",
               test_name, exp_data, exp_last, act_data, act_last);
    end
  endtask

  task automatic check_resp(input burst_len_t exp_len, input burst_len_t act_len);
    if (exp_len !== act_len) begin
      b_errors++;
      $display("error %s: response expected len %0d, actual len %0d",
               test_name, exp_len, act_len);
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (awvalid && awready) begin
        obs_aw_addr.push_back(awaddr);
        obs_aw_len.push_back(awlen);
        aw_seen++;
      end
      if (wvalid && wready) begin
        obs_w_data.push_back(wdata);
        obs_w_last.push_back(wlast);
        w_seen++;
      end
      if (write_resp_read && write_resp_empty_n) begin
        obs_resp.push_back(write_resp_dout);
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      while (obs_aw_addr.size() > 0) begin
        if (exp_aw_addr.size() == 0) begin
          other_errors++;
          $display("%s: an AW burst at %h came with none expected", test_name, obs_aw_addr[0]);
          void'(obs_aw_addr.pop_front());
          void'(obs_aw_len.pop_front());
        end else begin
          check_burst(exp_aw_addr.pop_front(), exp_aw_len.pop_front(),
                      obs_aw_addr.pop_front(), obs_aw_len.pop_front());
        end
      end
      while (obs_w_data.size() > 0) begin
        if (exp_w_data.size() == 0) begin
          other_errors++;
          $display("%s: a W beat %h came with none expected", test_name, obs_w_data[0]);
          void'(obs_w_data.pop_front());
          void'(obs_w_last.pop_front());
        end else begin
          check_beat(exp_w_data.pop_front(), exp_w_last.pop_front(),
                     obs_w_data.pop_front(), obs_w_last.pop_front());
        end
      end
      while (obs_resp.size() > 0) begin
        if (exp_resp.size() == 0) begin
          other_errors++;
          $display("%s: a write response came with none expected", test_name);
          void'(obs_resp.pop_front());
        end else begin
          check_resp(exp_resp.pop_front(), obs_resp.pop_front());
        end
      end
    end
  end

  task automatic add_run(input addr_t start, input int count);
    int i;
    for (i = 0; i < count; i++) begin
      grp_addr.push_back(start + addr_t'(i) * step);
      grp_data.push_back(data_t'($random(seed)));
    end
  endtask

  task automatic add_random_run(input int count);
    addr_t a;
    int    rnd;
    int    i;
    rnd = $random(seed);
    a   = addr_t'(rnd & 32'h000f_fffc);
    for (i = 0; i < count; i++) begin
      grp_addr.push_back(a);
      grp_data.push_back(data_t'($random(seed)));
      rnd = $random(seed);
      // mostly consecutive with an occasional jump
      if (rnd[1:0] == 2'b00) begin
        a = addr_t'(rnd & 32'h000f_fffc);
      end else begin
        a = a + step;
      end
    end
  endtask

  task automatic run_group(input string name);
    int bursts;
    int i;
    test_name = name;
    bursts    = aw_total;
    split_bursts(grp_addr, grp_data);
    bursts = aw_total - bursts;
    for (i = 0; i < grp_addr.size(); i++) begin
      while (!(write_addr_full_n && write_data_full_n)) begin
        @(posedge clk);
        #1;
      end
      write_addr_din   = grp_addr[i];
      write_addr_write = 1'b1;
      write_data_din   = grp_data[i];
      write_data_write = 1'b1;
      @(posedge clk);
      #1;
    end
    write_addr_write = 1'b0;
    write_data_write = 1'b0;
    while (aw_seen < aw_total || w_seen < w_total) begin
      @(posedge clk);
      #1;
    end
    repeat (int'(max_wait) + 21) @(posedge clk);
    #1;
    // responses are collected late after the bursts went out
    for (i = 0; i < bursts; i++) begin
      while (!write_resp_empty_n) begin
        @(posedge clk);
        #1;
      end
      write_resp_read = 1'b1;
      @(posedge clk);
      #1;
      write_resp_read = 1'b0;
    end
    grp_addr.delete();
    grp_data.delete();
  endtask

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("errors: aw %0d, w %0d, b %0d, other %0d",
             aw_errors, w_errors, b_errors, other_errors);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rst              = 1'b1;
    write_addr_din   = '0;
    write_addr_write = 1'b0;
    write_data_din   = '0;
    write_data_write = 1'b0;
    write_resp_read  = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    add_run(addr_t'(32'h1000), 3);
    run_group("short_run");
    add_run(addr_t'(32'h2000), 10);
    run_group("split_run");
    add_run(addr_t'(32'h3000), 2);
    add_run(addr_t'(32'h3100), 3);
    add_run(addr_t'(32'h3200), 1);
    run_group("gap_run");
    add_run(addr_t'(32'h4000), 1);
    run_group("single_addr");
    add_random_run(12);
    run_group("random_a");
    add_random_run(12);
    run_group("random_b");
    repeat (2) @(posedge clk);
    if (exp_aw_addr.size() + exp_w_data.size() + exp_resp.size() != 0) begin
      other_errors++;
      $display("some expected bursts, beats or responses never showed up");
    end
    // every response was popped, so the response buffer must be empty
    if (write_resp_empty_n) begin
      other_errors++;
      $display("an extra write response is left over after the last group");
    end
    $display("errors: aw %0d, w %0d, b %0d, other %0d",
             aw_errors, w_errors, b_errors, other_errors);
    if (aw_errors + w_errors + b_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_axi_slave.sv */
`default_nettype none

module tb_axi_slave (
  input  wire  clk,
  input  wire  rst,
  output logic awready,
  input  wire  wvalid,
  output logic wready,
  input  wire  wlast,
  output logic bvalid,
  input  wire  bready
);

  timeunit 1ns;
  timeprecision 1ps;

  int   seed = 32'h52c4;
  int   rnd;
  int   pending;
  int   wait_cnt;
  logic in_reset;
  logic last_fire;
  logic b_fire;

  initial begin
    awready  = 1'b0;
    wready   = 1'b0;
    bvalid   = 1'b0;
    pending  = 0;
    wait_cnt = 4;
    forever begin
      @(posedge clk);
      // handshakes as seen at the edge
      in_reset  = rst;
      last_fire = wvalid && wready && wlast;
      b_fire    = bvalid && bready;
      #1;
      rnd = $random(seed);
      if (in_reset) begin
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        pending  = 0;
        wait_cnt = 4;
      end else begin
        awready = rnd[0];
        wready  = rnd[3];
        if (b_fire) begin
          bvalid = 1'b0;
          pending--;
        end
        if (last_fire) begin
          pending++;
        end
        // one B per finished burst, after a random delay
        if (!bvalid && pending > 0) begin
          if (wait_cnt == 0) begin
            bvalid   = 1'b1;
            wait_cnt = 3 + int'(rnd[10:8]);
          end else begin
            wait_cnt--;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/async_mmap_write.sv */
`default_nettype none

`include "mmap_defines.svh"

module async_mmap_write
  import mmap_pkg::*;
(
  input  wire             clk,
  input  wire             rst,

  input  wire wait_t      max_wait_time,
  input  wire burst_len_t max_burst_len,

  // user side
  input  wire addr_t      write_addr_din,
  input  wire             write_addr_write,
  output logic            write_addr_full_n,
  input  wire data_t      write_data_din,
  input  wire             write_data_write,
  output logic            write_data_full_n,
  output burst_len_t      write_resp_dout,
  input  wire             write_resp_read,
  output logic            write_resp_empty_n,

  // AXI write channels
  output logic            m_axi_awvalid,
  input  wire             m_axi_awready,
  output addr_t           m_axi_awaddr,
  output burst_len_t      m_axi_awlen,
  output logic            m_axi_wvalid,
  input  wire             m_axi_wready,
  output data_t           m_axi_wdata,
  output logic            m_axi_wlast,
  input  wire             m_axi_bvalid,
  output logic            m_axi_bready
);

  localparam int burst_width = `MMAP_LEN_WIDTH + `MMAP_ADDR_WIDTH;

  addr_t                  addr_dout;
  logic                   addr_empty_n;
  logic                   addr_read;
  addr_t                  burst_addr_din;
  burst_len_t             burst_len_din;
  logic                   burst_write;
  logic                   burst_full_n;
  logic [burst_width-1:0] burst_dout;
  logic                   burst_empty_n;
  logic                   burst_read;
  burst_len_t             last_len_din;
  logic                   last_len_write;
  logic                   last_len_full_n;
  burst_len_t             req_len_din;
  logic                   req_len_write;
  logic                   req_len_full_n;

  // single addresses from the user
  sync_fifo #(
    .width    (`MMAP_ADDR_WIDTH),
    .depth    (`MMAP_FIFO_DEPTH),
    .depth_log(`MMAP_FIFO_DEPTH_LOG)
  ) u_addr_fifo (
    .clk    (clk),
    .rst    (rst),
    .din    (write_addr_din),
    .write  (write_addr_write),
    .full_n (write_addr_full_n),
    .dout   (addr_dout),
    .read   (addr_read),
    .empty_n(addr_empty_n)
  );

  burst_detector u_burst_detector (
    .clk            (clk),
    .rst            (rst),
    .max_wait_time  (max_wait_time),
    .max_burst_len  (max_burst_len),
    .addr_dout      (addr_dout),
    .addr_empty_n   (addr_empty_n),
    .addr_read      (addr_read),
    .burst_addr_din (burst_addr_din),
    .burst_len_din  (burst_len_din),
    .burst_write    (burst_write),
    .burst_full_n   (burst_full_n),
    .last_len_din   (last_len_din),
    .last_len_write (last_len_write),
    .last_len_full_n(last_len_full_n),
    .req_len_din    (req_len_din),
    .req_len_write  (req_len_write),
    .req_len_full_n (req_len_full_n)
  );

  // length in the upper bits, address below
  sync_fifo #(
    .width    (burst_width),
    .depth    (`MMAP_FIFO_DEPTH),
    .depth_log(`MMAP_FIFO_DEPTH_LOG)
  ) u_burst_fifo (
    .clk    (clk),
    .rst    (rst),
    .din    ({burst_len_din, burst_addr_din}),
    .write  (burst_write),
    .full_n (burst_full_n),
    .dout   (burst_dout),
    .read   (burst_read),
    .empty_n(burst_empty_n)
  );

  // AW channel straight off the burst FIFO head
  assign m_axi_awvalid = burst_empty_n;
  assign burst_read    = burst_empty_n && m_axi_awready;
  assign {m_axi_awlen, m_axi_awaddr} = burst_dout;

  w_channel u_w_channel (
    .clk              (clk),
    .rst              (rst),
    .write_data_din   (write_data_din),
    .write_data_write (write_data_write),
    .write_data_full_n(write_data_full_n),
    .last_len_din     (last_len_din),
    .last_len_write   (last_len_write),
    .last_len_full_n  (last_len_full_n),
    .m_axi_wvalid     (m_axi_wvalid),
    .m_axi_wready     (m_axi_wready),
    .m_axi_wdata      (m_axi_wdata),
    .m_axi_wlast      (m_axi_wlast)
  );

  write_resp_tracker u_write_resp_tracker (
    .clk               (clk),
    .rst               (rst),
    .req_len_din       (req_len_din),
    .req_len_write     (req_len_write),
    .req_len_full_n    (req_len_full_n),
    .m_axi_bvalid      (m_axi_bvalid),
    .m_axi_bready      (m_axi_bready),
    .write_resp_dout   (write_resp_dout),
    .write_resp_read   (write_resp_read),
    .write_resp_empty_n(write_resp_empty_n)
  );

endmodule

`default_nettype wire

/* source/write_resp_tracker.sv */
`default_nettype none

`include "mmap_defines.svh"

module write_resp_tracker
  import mmap_pkg::*;
(
  input  wire             clk,
  input  wire             rst,

  // length of each issued burst
  input  wire burst_len_t req_len_din,
  input  wire             req_len_write,
  output logic            req_len_full_n,

  // AXI B channel
  input  wire             m_axi_bvalid,
  output logic            m_axi_bready,

  // completed burst lengths to the user
  output burst_len_t      write_resp_dout,
  input  wire             write_resp_read,
  output logic            write_resp_empty_n
);

  burst_len_t req_dout;
  logic       req_empty_n;
  logic       resp_full_n;
  logic       b_fire;

  sync_fifo #(
    .width    (`MMAP_LEN_WIDTH),
    .depth    (`MMAP_FIFO_DEPTH),
    .depth_log(`MMAP_FIFO_DEPTH_LOG)
  ) u_req_fifo (
    .clk    (clk),
    .rst    (rst),
    .din    (req_len_din),
    .write  (req_len_write),
    .full_n (req_len_full_n),
    .dout   (req_dout),
    .read   (b_fire),
    .empty_n(req_empty_n)
  );

  // B responses come back in issue order
  assign m_axi_bready = req_empty_n && resp_full_n;
  assign b_fire       = m_axi_bvalid && m_axi_bready;

  sync_fifo #(
    .width    (`MMAP_LEN_WIDTH),
    .depth    (`MMAP_FIFO_DEPTH),
    .depth_log(`MMAP_FIFO_DEPTH_LOG)
  ) u_resp_fifo (
    .clk    (clk),
    .rst    (rst),
    .din    (req_dout),
    .write  (b_fire),
    .full_n (resp_full_n),
    .dout   (write_resp_dout),
    .read   (write_resp_read),
    .empty_n(write_resp_empty_n)
  );

endmodule

`default_nettype wire

/* source/w_channel.sv */
`default_nettype none

`include "mmap_defines.svh"

module w_channel
  import mmap_pkg::*;
(
  input  wire             clk,
  input  wire             rst,

  // user write data
  input  wire data_t      write_data_din,
  input  wire             write_data_write,
  output logic            write_data_full_n,

  // burst lengths from the detector
  input  wire burst_len_t last_len_din,
  input  wire             last_len_write,
  output logic            last_len_full_n,

  // AXI W channel
  output logic            m_axi_wvalid,
  input  wire             m_axi_wready,
  output data_t           m_axi_wdata,
  output logic            m_axi_wlast
);

  data_t      data_dout;
  logic       data_empty_n;
  burst_len_t len_dout;
  logic       len_empty_n;
  logic       len_read;
  logic       flag_din;
  logic       flag_write;
  logic       flag_full_n;
  logic       flag_dout;
  logic       flag_empty_n;
  logic       beat_pop;
  burst_len_t beat_idx;

  sync_fifo #(
    .width    (`MMAP_DATA_WIDTH),
    .depth    (`MMAP_FIFO_DEPTH),
    .depth_log(`MMAP_FIFO_DEPTH_LOG)
  ) u_data_fifo (
    .clk    (clk),
    .rst    (rst),
    .din    (write_data_din),
    .write  (write_data_write),
    .full_n (write_data_full_n),
    .dout   (data_dout),
    .read   (beat_pop),
    .empty_n(data_empty_n)
  );

  sync_fifo #(
    .width    (`MMAP_LEN_WIDTH),
    .depth    (`MMAP_FIFO_DEPTH),
    .depth_log(`MMAP_FIFO_DEPTH_LOG)
  ) u_len_fifo (
    .clk    (clk),
    .rst    (rst),
    .din    (last_len_din),
    .write  (last_len_write),
    .full_n (last_len_full_n),
    .dout   (len_dout),
    .read   (len_read),
    .empty_n(len_empty_n)
  );

  // one flag per beat, set on the final beat of a burst
  assign flag_write = len_empty_n && flag_full_n;
  assign flag_din   = beat_idx == len_dout;
  assign len_read   = flag_write && flag_din;

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_idx <= '0;
    end else if (flag_write) begin
      beat_idx <= flag_din ? '0 : beat_idx + 1'b1;
    end
  end

  sync_fifo #(
    .width    (1),
    .depth    (`MMAP_FIFO_DEPTH),
    .depth_log(`MMAP_FIFO_DEPTH_LOG)
  ) u_last_fifo (
    .clk    (clk),
    .rst    (rst),
    .din    (flag_din),
    .write  (flag_write),
    .full_n (flag_full_n),
    .dout   (flag_dout),
    .read   (beat_pop),
    .empty_n(flag_empty_n)
  );

  // data and flag leave together
  assign m_axi_wvalid = data_empty_n && flag_empty_n;
  assign beat_pop     = m_axi_wvalid && m_axi_wready;
  assign m_axi_wdata  = data_dout;
  assign m_axi_wlast  = flag_dout;

endmodule

`default_nettype wire

/* source/burst_detector.sv */
`default_nettype none

`include "mmap_defines.svh"

module burst_detector
  import mmap_pkg::*;
(
  input  wire             clk,
  input  wire             rst,

  // burst inference settings
  input  wire wait_t      max_wait_time,
  input  wire burst_len_t max_burst_len,

  // single word addresses
  input  wire addr_t      addr_dout,
  input  wire             addr_empty_n,
  output logic            addr_read,

  // burst address and length for AW
  output addr_t           burst_addr_din,
  output burst_len_t      burst_len_din,
  output logic            burst_write,
  input  wire             burst_full_n,

  // length copy for the last-flag generator
  output burst_len_t      last_len_din,
  output logic            last_len_write,
  input  wire             last_len_full_n,

  // length copy for the response tracker
  output burst_len_t      req_len_din,
  output logic            req_len_write,
  input  wire             req_len_full_n
);

  burst_state_t state;
  addr_t        start_addr;
  addr_t        next_addr;
  burst_len_t   beat_cnt;
  wait_t        idle_cnt;

  logic all_ready;
  logic at_limit;
  logic addr_match;
  logic close_burst;
  logic emit;

  // all three consumers must take the burst in the same cycle
  assign all_ready  = burst_full_n && last_len_full_n && req_len_full_n;
  assign at_limit   = beat_cnt == max_burst_len;
  assign addr_match = addr_dout == next_addr;

  always_comb begin
    close_burst = 1'b0;
    if (state == st_collect) begin
      if (at_limit) begin
        close_burst = 1'b1;
      end else if (addr_empty_n) begin
        // a gap in the address sequence ends the burst
        close_burst = !addr_match;
      end else begin
        close_burst = idle_cnt == max_wait_time;
      end
    end
  end

  assign emit = close_burst && all_ready;

  // the closing address stays at the head for the next burst
  assign addr_read = addr_empty_n && ((state == st_idle) || !close_burst);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      beat_cnt <= '0;
      idle_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (addr_empty_n) begin
            state    <= st_collect;
            beat_cnt <= '0;
            idle_cnt <= '0;
          end
        end
        st_collect: begin
          if (emit) begin
            state <= st_idle;
          end else if (addr_read) begin
            beat_cnt <= beat_cnt + 1'b1;
            idle_cnt <= '0;
          end else if (!close_burst) begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // only consecutive addresses get here, so next is always head plus one word
  always_ff @(posedge clk) begin
    if (addr_read) begin
      if (state == st_idle) begin
        start_addr <= addr_dout;
      end
      next_addr <= addr_dout + addr_t'(`MMAP_BYTES_PER_BEAT);
    end
  end

  assign burst_addr_din = start_addr;
  assign burst_len_din  = beat_cnt;
  assign last_len_din   = beat_cnt;
  assign req_len_din    = beat_cnt;

  assign burst_write    = emit;
  assign last_len_write = emit;
  assign req_len_write  = emit;

endmodule

`default_nettype wire

/* source/sync_fifo.sv */
`default_nettype none

`include "mmap_defines.svh"

module sync_fifo #(
  parameter int width     = `MMAP_DATA_WIDTH,
  parameter int depth     = `MMAP_FIFO_DEPTH,
  parameter int depth_log = `MMAP_FIFO_DEPTH_LOG
) (
  input  wire              clk,
  input  wire              rst,
  input  wire  [width-1:0] din,
  input  wire              write,
  output logic             full_n,
  output logic [width-1:0] dout,
  input  wire              read,
  output logic             empty_n
);

  localparam logic [depth_log-1:0] last_slot = depth_log'(depth - 1);
  localparam logic [depth_log:0]   full_count = (depth_log + 1)'(depth);

  logic [width-1:0]     mem [depth];
  logic [depth_log-1:0] wr_ptr;
  logic [depth_log-1:0] rd_ptr;
  logic [depth_log:0]   count;
  logic                 do_write;
  logic                 do_read;

  // strobes on a full or empty buffer are dropped
  assign do_write = write && full_n;
  assign do_read  = read && empty_n;

  assign full_n  = count != full_count;
  assign empty_n = count != '0;

  // head is always visible
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/mmap_pkg.sv */
`default_nettype none

`include "mmap_defines.svh"

package mmap_pkg;

  // one byte address
  typedef logic [`MMAP_ADDR_WIDTH-1:0] addr_t;

  // one data word
  typedef logic [`MMAP_DATA_WIDTH-1:0] data_t;

  // AXI length, beats minus one
  typedef logic [`MMAP_LEN_WIDTH-1:0] burst_len_t;

  // wait-time setting and idle timer
  typedef logic [`MMAP_WAIT_WIDTH-1:0] wait_t;

  // burst detector states
  typedef enum logic [0:0] {
    st_idle,
    st_collect
  } burst_state_t;

endpackage

`default_nettype wire

/* source/mmap_defines.svh */
`ifndef MMAP_DEFINES_SVH
`define MMAP_DEFINES_SVH

// byte address width on the user and AXI side
`define MMAP_ADDR_WIDTH 32

// one data word, one AXI beat
`define MMAP_DATA_WIDTH 32

// address step from one beat to the next
`define MMAP_BYTES_PER_BEAT 4

// AXI length field, beats minus one
`define MMAP_LEN_WIDTH 8

// idle timer of the burst detector
`define MMAP_WAIT_WIDTH 4

// default buffer size, depth_log must match depth
`define MMAP_FIFO_DEPTH 16
`define MMAP_FIFO_DEPTH_LOG 4

`endif
